// File: src/coil_sense_cfg.svh
`ifndef COIL_SENSE_CFG_SVH
`define COIL_SENSE_CFG_SVH

// Signed coil current with a 12-bit magnitude
// Rails at plus and minus 4095
`define CURRENT_W 13

// Current change per clock
`define COIL_STEP 16 // Same step for drive and decay

// Measurement window of 2**8 clocks
`define DUTY_WIN_LOG2 8

// Duty width, also the width of the comparator target
`define DUTY_W 12

`endif

// File: src/coil_pkg.sv
`include "coil_sense_cfg.svh"

package coil_pkg;

  // Gate lines of one H-bridge, half-bridge 1 first
  typedef struct packed {
    logic high_1; // Side 1 to supply
    logic low_1;  // Side 1 to ground
    logic high_2; // Side 2 to supply
    logic low_2;  // Side 2 to ground
  } bridge_gates_t;

  // One current sample of a coil
  typedef struct packed {
    logic signed [`CURRENT_W-1:0] current; // Positive from side 1 to side 2
    logic                         fault;   // Sticky shoot-through
  } coil_sample_t;

endpackage

// File: src/loop_pkg.sv
`include "coil_sense_cfg.svh"

package loop_pkg;

  // Result of one PWM measurement window
  typedef struct packed {
    logic               valid; // One-cycle strobe
    logic [`DUTY_W-1:0] duty;
  } duty_meas_t;

  // Chopper comparator output
  typedef struct packed {
    logic               cmp;    // Magnitude at or above target
    logic [`DUTY_W-1:0] target; // Latched duty
  } cmp_status_t;

endpackage

// File: src/pwm_duty.sv
`timescale 1ns/100ps
`include "coil_sense_cfg.svh"

module pwm_duty import loop_pkg::*; (
  input  logic       CLK,
  input  logic       resetn,
  input  logic       pwm,
  output duty_meas_t duty
);

  localparam int WIN_W    = `DUTY_WIN_LOG2;
  localparam int CNT_W    = WIN_W + 1;        // Room for a window that is all high
  localparam int SHIFT    = `DUTY_W - WIN_W;
  localparam int SCALED_W = CNT_W + SHIFT;

  logic [WIN_W-1:0]    win_cnt;
  logic [CNT_W-1:0]    high_cnt;
  logic [CNT_W-1:0]    high_total;
  logic                win_last;
  logic [SCALED_W-1:0] scaled;
  logic [`DUTY_W-1:0]  duty_sat;

  assign win_last   = (win_cnt == {WIN_W{1'b1}});
  assign high_total = high_cnt + CNT_W'(pwm);     // Count includes this sample

  // A full window clips to the top code
  assign scaled   = SCALED_W'(high_total) << SHIFT;
  assign duty_sat = (|scaled[SCALED_W-1:`DUTY_W]) ? '1 : scaled[`DUTY_W-1:0];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      win_cnt  <= '0;
      high_cnt <= '0;
    end else begin
      win_cnt <= win_cnt + 1'b1; // Wraps into the next window
      if (win_last) begin
        high_cnt <= '0;
      end else begin
        high_cnt <= high_total;
      end
    end
  end

  // Strobe and value land on the clock after the last sample
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      duty <= '0;
    end else begin
      duty.valid <= win_last;
      if (win_last) begin
        duty.duty <= duty_sat;
      end
    end
  end

  a_single_strobe: assert property (
    @(posedge CLK) disable iff (!resetn)
    duty.valid |=> !duty.valid
  ) else $error("duty strobe high on consecutive cycles");

endmodule

// File: src/hbridge_coil.sv
`timescale 1ns/100ps
`include "coil_sense_cfg.svh"

module hbridge_coil import coil_pkg::*; (
  input  logic          CLK,
  input  logic          resetn,
  input  bridge_gates_t gates,
  output coil_sample_t  sample
);

  localparam int ACC_W = `CURRENT_W + 1; // One guard bit for the step
  localparam logic signed [ACC_W-1:0] I_MAX = ACC_W'(2 ** (`CURRENT_W - 1) - 1);
  localparam logic signed [ACC_W-1:0] STEP  = ACC_W'(`COIL_STEP);

  typedef enum logic [2:0] {
    BR_HOLD,
    BR_POS,
    BR_NEG,
    BR_DECAY,
    BR_SHOOT
  } bridge_state_t;

  bridge_state_t           state;
  logic [3:0]              gate_code;
  logic                    shoot;
  logic signed [ACC_W-1:0] cur_ext;
  logic signed [ACC_W-1:0] cur_up;
  logic signed [ACC_W-1:0] cur_dn;
  logic signed [ACC_W-1:0] cur_next;

  assign gate_code = {gates.high_1, gates.low_1, gates.high_2, gates.low_2};
  assign shoot     = (gates.high_1 && gates.low_1) || (gates.high_2 && gates.low_2);

  always_comb begin
    if (shoot) begin
      state = BR_SHOOT;
    end else begin
      case (gate_code)
        4'b1001: state = BR_POS;   // high_1 with low_2
        4'b0110: state = BR_NEG;   // high_2 with low_1
        4'b0000,
        4'b0101: state = BR_DECAY; // Off or both lows on
        default: state = BR_HOLD;
      endcase
    end
  end

  assign cur_ext = {sample.current[`CURRENT_W-1], sample.current};
  assign cur_up  = cur_ext + STEP;
  assign cur_dn  = cur_ext - STEP;

  always_comb begin
    cur_next = cur_ext;
    case (state)
      BR_POS: begin
        cur_next = (cur_up > I_MAX) ? I_MAX : cur_up;
      end
      BR_NEG: begin
        cur_next = (cur_dn < -I_MAX) ? -I_MAX : cur_dn;
      end
      BR_DECAY: begin
        // Step toward zero without crossing it
        if (cur_ext > STEP) begin
          cur_next = cur_dn;
        end else if (cur_ext < -STEP) begin
          cur_next = cur_up;
        end else begin
          cur_next = '0;
        end
      end
      default:  cur_next = cur_ext;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sample <= '0;
    end else if (sample.fault || state == BR_SHOOT) begin
      sample.fault   <= 1'b1; // Held until reset
      sample.current <= '0;
    end else begin
      sample.current <= cur_next[`CURRENT_W-1:0];
    end
  end

  a_current_range: assert property (
    @(posedge CLK) disable iff (!resetn)
    (cur_ext <= I_MAX) && (cur_ext >= -I_MAX)
  ) else $error("coil current beyond rail");

  a_fault_zero: assert property (
    @(posedge CLK) disable iff (!resetn)
    sample.fault |-> (sample.current == '0)
  ) else $error("current not zero while faulted");

endmodule

// File: src/current_cmp.sv
`timescale 1ns/100ps
`include "coil_sense_cfg.svh"

module current_cmp import coil_pkg::*, loop_pkg::*; (
  input  logic         CLK,
  input  logic         resetn,
  input  duty_meas_t   duty,
  input  coil_sample_t sample,
  output cmp_status_t  status
);

  logic [`CURRENT_W-1:0] cur_abs;
  logic [`CURRENT_W-1:0] target_ext;
  logic [`DUTY_W-1:0]    target;
  logic                  cmp_bit;
  logic                  cmp_next;

  // Magnitude of the signed current
  always_comb begin
    if (sample.current[`CURRENT_W-1]) begin
      cur_abs = -sample.current;
    end else begin
      cur_abs = sample.current;
    end
  end

  assign target_ext = {{(`CURRENT_W - `DUTY_W){1'b0}}, target};
  assign cmp_next   = (cur_abs >= target_ext); // Unsigned compare

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      target  <= '0;
      cmp_bit <= 1'b1; // 0 is at least 0
    end else begin
      cmp_bit <= cmp_next;
      if (duty.valid) begin
        target <= duty.duty; // Taken on the strobe
      end
    end
  end

  assign status.cmp    = cmp_bit;
  assign status.target = target;

  a_target_on_strobe: assert property (
    @(posedge CLK) disable iff (!resetn)
    $changed(target) |-> $past(duty.valid)
  ) else $error("target changed without a duty strobe");

endmodule

// File: src/coil_sense_top.sv
`timescale 1ns/100ps

module coil_sense_top import coil_pkg::*, loop_pkg::*; (
  input  logic          CLK,
  input  logic          resetn,
  input  bridge_gates_t gates_a,
  input  bridge_gates_t gates_b,
  input  logic          vref_a,
  input  logic          vref_b,
  output coil_sample_t  sample_a,
  output coil_sample_t  sample_b,
  output cmp_status_t   status_a,
  output cmp_status_t   status_b
);

  duty_meas_t duty_a;
  duty_meas_t duty_b;

  // Coil A
  pwm_duty u_duty_a (
    .CLK    (CLK),
    .resetn (resetn),
    .pwm    (vref_a),
    .duty   (duty_a)
  );

  hbridge_coil u_coil_a (
    .CLK    (CLK),
    .resetn (resetn),
    .gates  (gates_a),
    .sample (sample_a)
  );

  current_cmp u_cmp_a (
    .CLK    (CLK),
    .resetn (resetn),
    .duty   (duty_a),
    .sample (sample_a),
    .status (status_a)
  );

  // Coil B
  pwm_duty u_duty_b (
    .CLK    (CLK),
    .resetn (resetn),
    .pwm    (vref_b),
    .duty   (duty_b)
  );

  hbridge_coil u_coil_b (
    .CLK    (CLK),
    .resetn (resetn),
    .gates  (gates_b),
    .sample (sample_b)
  );

  current_cmp u_cmp_b (
    .CLK    (CLK),
    .resetn (resetn),
    .duty   (duty_b),
    .sample (sample_b),
    .status (status_b)
  );

endmodule

// File: bench/coil_sense_tb.sv
`timescale 1ns/100ps
`include "coil_sense_cfg.svh"

module coil_sense_tb import coil_pkg::*, loop_pkg::*;;

  localparam int CLK_PERIOD = 40;
  localparam int WIN        = 1 << `DUTY_WIN_LOG2;
  localparam int MAX_SEG    = 32;
  localparam int SEG_WORDS  = 8;    // Words per trace line
  localparam int WD_MARGIN  = 1000;
  localparam bridge_gates_t GATES_HOLD = 4'b1000; // high_1 alone holds the current

  logic          CLK = 1'b0;
  logic          resetn;
  bridge_gates_t gates_a;
  bridge_gates_t gates_b;
  logic          vref_a;
  logic          vref_b;
  coil_sample_t  sample_a;
  coil_sample_t  sample_b;
  cmp_status_t   status_a;
  cmp_status_t   status_b;

  logic [31:0]   trace_mem [0:MAX_SEG*SEG_WORDS-1];
  int            n_seg;
  int            seg_sel    [MAX_SEG];
  bridge_gates_t seg_gates  [MAX_SEG];
  int            seg_h      [MAX_SEG];
  int            seg_len    [MAX_SEG];
  int            seg_end    [MAX_SEG]; // Clock count at the segment's last sample
  coil_sample_t  exp_sample [MAX_SEG];
  cmp_status_t   exp_status [MAX_SEG];
  duty_meas_t    exp_duty   [MAX_SEG];
  int            last_h     [2];
  int            cyc = 0;
  int            sample_idx = 0;
  int            status_idx = 0;
  bit            trace_ready = 1'b0;
  longint        wd_ns;

  coil_sense_top u_dut (
    .CLK      (CLK),
    .resetn   (resetn),
    .gates_a  (gates_a),
    .gates_b  (gates_b),
    .vref_a   (vref_a),
    .vref_b   (vref_b),
    .sample_a (sample_a),
    .sample_b (sample_b),
    .status_a (status_a),
    .status_b (status_b)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // Clocks since reset release
  always @(posedge CLK) begin
    if (resetn) begin
      cyc <= cyc + 1;
    end
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_sample(input string name, input coil_sample_t exp,
                              input coil_sample_t got);
    if (got !== exp) begin
      abort_run($sformatf("ERROR: %s expected current=%h fault=%h, got current=%h fault=%h",
                          name, exp.current, exp.fault, got.current, got.fault));
    end
  endtask

  task automatic check_status(input string name, input cmp_status_t exp,
                              input cmp_status_t got);
    if (got !== exp) begin
      abort_run($sformatf("ERROR: %s expected cmp=%h target=%h, got cmp=%h target=%h",
                          name, exp.cmp, exp.target, got.cmp, got.target));
    end
  endtask

  task automatic check_duty(input string name, input duty_meas_t exp,
                            input duty_meas_t got);
    if (got !== exp) begin
      abort_run($sformatf("ERROR: %s expected valid=%h duty=%h, got valid=%h duty=%h",
                          name, exp.valid, exp.duty, got.valid, got.duty));
    end
  endtask

  task automatic check_strobe(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      abort_run($sformatf("ERROR: %s expected %h got %h", name, exp, got));
    end
  endtask

  task automatic load_trace();
    int base;
    int total;
    foreach (trace_mem[i]) begin
      trace_mem[i] = '1; // Marks the end of the trace
    end
    $readmemh("bench/coil_trace.txt", trace_mem);
    n_seg = 0;
    total = 0;
    while (n_seg < MAX_SEG && trace_mem[n_seg*SEG_WORDS] != 32'hFFFF_FFFF) begin
      base = n_seg * SEG_WORDS;
      if (trace_mem[base+3] == 0) begin
        abort_run($sformatf("Trace segment %0d has no windows", n_seg));
      end
      seg_sel[n_seg]            = int'(trace_mem[base][0]);
      seg_gates[n_seg]          = bridge_gates_t'(trace_mem[base+1][3:0]);
      seg_h[n_seg]              = int'(trace_mem[base+2]);
      seg_len[n_seg]            = int'(trace_mem[base+3]) * WIN;
      total                     = total + seg_len[n_seg];
      seg_end[n_seg]            = total;
      exp_sample[n_seg].current = trace_mem[base+4][`CURRENT_W-1:0];
      exp_sample[n_seg].fault   = trace_mem[base+7][0];
      exp_status[n_seg].cmp     = trace_mem[base+6][0];
      exp_status[n_seg].target  = trace_mem[base+5][`DUTY_W-1:0];
      exp_duty[n_seg].valid     = 1'b1; // Last window closes on the final clock
      exp_duty[n_seg].duty      = trace_mem[base+5][`DUTY_W-1:0];
      n_seg++;
    end
    if (n_seg == 0) begin
      abort_run("The trace file holds no segments");
    end
    wd_ns = longint'(total + WD_MARGIN) * CLK_PERIOD;
    trace_ready = 1'b1;
  endtask

  task automatic check_reset_state();
    cmp_status_t st;
    st     = '0;
    st.cmp = 1'b1; // Zero current meets a zero target
    check_sample("sample_a", '0, sample_a);
    check_sample("sample_b", '0, sample_b);
    check_status("status_a", st, status_a);
    check_status("status_b", st, status_b);
    check_duty("duty_a", '0, u_dut.duty_a);
    check_duty("duty_b", '0, u_dut.duty_b);
  endtask

  // Other coil holds while the selected one runs the pattern
  task automatic run_segment(input int s);
    int   pos;
    logic hi_sel;
    logic hi_other;
    for (int c = 0; c < seg_len[s]; c++) begin
      pos      = c % WIN;
      hi_sel   = (pos < seg_h[s]);
      hi_other = (pos < last_h[1 - seg_sel[s]]);
      if (seg_sel[s] == 0) begin
        gates_a <= seg_gates[s];
        vref_a  <= hi_sel;
        gates_b <= GATES_HOLD;
        vref_b  <= hi_other;
      end else begin
        gates_a <= GATES_HOLD;
        vref_a  <= hi_other;
        gates_b <= seg_gates[s];
        vref_b  <= hi_sel;
      end
      @(posedge CLK);
    end
    last_h[seg_sel[s]] = seg_h[s];
  endtask

  always @(negedge CLK) begin
    if (resetn) begin
      check_strobe("duty_a.valid", (cyc != 0) && (cyc % WIN == 0), u_dut.duty_a.valid);
      check_strobe("duty_b.valid", (cyc != 0) && (cyc % WIN == 0), u_dut.duty_b.valid);
      if (sample_idx < n_seg && cyc == seg_end[sample_idx]) begin
        if (seg_sel[sample_idx] == 0) begin
          check_sample("sample_a", exp_sample[sample_idx], sample_a);
          check_duty("duty_a", exp_duty[sample_idx], u_dut.duty_a);
        end else begin
          check_sample("sample_b", exp_sample[sample_idx], sample_b);
          check_duty("duty_b", exp_duty[sample_idx], u_dut.duty_b);
        end
        sample_idx = sample_idx + 1;
      end
      // Comparator sees the end current one clock later
      if (status_idx < n_seg && cyc == seg_end[status_idx] + 1) begin
        if (seg_sel[status_idx] == 0) begin
          check_status("status_a", exp_status[status_idx], status_a);
        end else begin
          check_status("status_b", exp_status[status_idx], status_b);
        end
        status_idx = status_idx + 1;
      end
    end
  end

  initial begin
    resetn    = 1'b0;
    gates_a   = '0;
    gates_b   = '0;
    vref_a    = 1'b0;
    vref_b    = 1'b0;
    last_h[0] = 0;
    last_h[1] = 0;
    load_trace();
    @(posedge CLK);
    @(negedge CLK);
    check_reset_state();
    @(posedge CLK);
    resetn <= 1'b1;
    for (int s = 0; s < n_seg; s++) begin
      run_segment(s);
    end
    gates_a <= GATES_HOLD;
    gates_b <= GATES_HOLD;
    vref_a  <= 1'b0;
    vref_b  <= 1'b0;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    if (sample_idx == n_seg && status_idx == n_seg) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      abort_run("Not every segment reached its end-of-segment check");
    end
  end

  initial begin
    wait (trace_ready);
    #(wd_ns);
    abort_run($sformatf("Timeout: the run did not finish within %0d ns", wd_ns));
  end

endmodule

// File: bench/coil_trace.txt
// sel gates pwm_high windows | cur target cmp fault at segment end, all hex
// sel 0 is coil A, 1 is coil B; gates are {high_1 low_1 high_2 low_2}
0 9 40  2 0FFF 400 1 0
0 6 FF  1 1FFF FF0 0 0
0 9 FF  1 0FFF FF0 1 0
0 9 100 2 0FFF FFF 1 0
0 0 01  2 0000 010 0 0
1 6 80  2 1001 800 1 0
1 9 01  1 0001 010 0 0
1 5 00  2 0000 000 1 0
0 9 20  2 0FFF 200 1 0
0 C 20  1 0000 200 0 1
1 9 100 2 0FFF FFF 1 0
0 9 10  2 0000 100 0 1
1 3 00  2 0000 000 1 1
0 6 00  2 0000 000 1 1

// File: src.f
+incdir+src
src/coil_pkg.sv
src/loop_pkg.sv
src/pwm_duty.sv
src/hbridge_coil.sv
src/current_cmp.sv
src/coil_sense_top.sv
bench/coil_sense_tb.sv

// File: Makefile
VERILATOR := verilator
TOP       := coil_sense_tb
RTL_TOP   := coil_sense_top
FILELIST  := src.f
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
LINTFLAGS := --lint-only --timing --timescale 1ns/100ps
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
PASS_TEXT := Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	@out=$$(./$(SIM) 2>&1); echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
